// ==== design/noc_bridge_pkg.sv ====
package noc_bridge_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int ID_W = 4;
    localparam int FLIT_W = 40;      // Data field of one stream beat.
    localparam int MESH_X = 4;
    localparam int MESH_Y = 4;
    localparam int COORD_X_W = $clog2(MESH_X);
    localparam int COORD_Y_W = $clog2(MESH_Y);

    typedef logic [COORD_X_W-1:0] coord_x_t;
    typedef logic [COORD_Y_W-1:0] coord_y_t;
    typedef logic [ID_W-1:0] axi_id_t;
    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [DATA_W/8-1:0] axi_strb_t;
    typedef logic [7:0] burst_len_t;
    typedef logic [7:0] pkt_count_t;

    // Codes 2 and 4 belonged to the read subheaders and stay unused.
    typedef enum logic [2:0] {
        ROUTING_HEADER = 3'd0,
        AW_SUBHEADER = 3'd1,
        W_DATA = 3'd3,
        B_SUBHEADER = 3'd5
    } flit_kind_t;

    // First flit of every packet, used by the routers for XY routing.
    typedef struct packed {
        logic [FLIT_W-8-2*(COORD_X_W+COORD_Y_W)-1:0] rsvd;
        pkt_count_t packet_count;
        coord_x_t src_x;
        coord_y_t src_y;
        coord_x_t dst_x;
        coord_y_t dst_y;
    } routing_header_t;

    typedef struct packed {
        logic [FLIT_W-(ID_W+ADDR_W+8+3+2)-1:0] rsvd;
        axi_id_t id;
        axi_addr_t addr;
        burst_len_t len;
        logic [2:0] size;
        logic [1:0] burst;
    } aw_subheader_t;

    typedef struct packed {
        logic [FLIT_W-DATA_W-1:0] rsvd;
        axi_data_t data;
    } w_flit_t;

    typedef struct packed {
        logic [FLIT_W-ID_W-1:0] rsvd;
        axi_id_t id;
    } b_subheader_t;

    typedef struct packed {
        logic [FLIT_W-1:0] tdata;
        axi_strb_t tstrb;
        flit_kind_t tid;
        logic tlast;
    } flit_t;

    typedef struct packed {
        axi_id_t awid;
        axi_addr_t awaddr;
        burst_len_t awlen;
        logic [2:0] awsize;
        logic [1:0] awburst;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t wdata;
        axi_strb_t wstrb;
        logic wlast;
    } axi_w_t;

    typedef struct packed {
        axi_id_t bid;
    } axi_b_t;

endpackage

// ==== design/write_packetizer.sv ====
`timescale 1ns/1ns

module write_packetizer #(
    parameter noc_bridge_pkg::coord_x_t ROUTER_X = '0,
    parameter noc_bridge_pkg::coord_y_t ROUTER_Y = '0
) (
    input  logic ACLK,
    input  logic ARESETn,

    input  noc_bridge_pkg::axi_aw_t s_axi_aw_i,
    input  logic s_axi_awvalid_i,
    output logic s_axi_awready_o,
    input  noc_bridge_pkg::axi_w_t s_axi_w_i,
    input  logic s_axi_wvalid_i,
    output logic s_axi_wready_o,

    output noc_bridge_pkg::flit_t m_axis_req_o,
    output logic m_axis_req_tvalid_o,
    input  logic m_axis_req_tready_i
);

    import noc_bridge_pkg::*;

    typedef enum logic [1:0] {HEADER, AW_SEND, W_SEND} state_t;

    state_t state, state_next;
    axi_id_t id_m1;
    routing_header_t header;
    aw_subheader_t aw_flit;
    w_flit_t w_flit;

    // Node n of the mesh is addressed by ID n + 1, row by row.
    always_comb begin
        id_m1 = s_axi_aw_i.awid - axi_id_t'(1);
        header.rsvd = '0;
        header.packet_count = s_axi_aw_i.awlen + pkt_count_t'(2);
        header.src_x = ROUTER_X;
        header.src_y = ROUTER_Y;
        header.dst_x = coord_x_t'(id_m1 % MESH_X);
        header.dst_y = coord_y_t'(id_m1 / MESH_X);

        aw_flit.rsvd = '0;
        aw_flit.id = s_axi_aw_i.awid;
        aw_flit.addr = s_axi_aw_i.awaddr;
        aw_flit.len = s_axi_aw_i.awlen;
        aw_flit.size = s_axi_aw_i.awsize;
        aw_flit.burst = s_axi_aw_i.awburst;

        w_flit.rsvd = '0;
        w_flit.data = s_axi_w_i.wdata;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= HEADER;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        s_axi_awready_o = 1'b0;
        s_axi_wready_o = 1'b0;
        m_axis_req_tvalid_o = 1'b0;
        m_axis_req_o.tdata = header;
        m_axis_req_o.tstrb = '1;
        m_axis_req_o.tid = ROUTING_HEADER;
        m_axis_req_o.tlast = 1'b0;
        case (state)
            HEADER: begin
                m_axis_req_tvalid_o = s_axi_awvalid_i;
                if (s_axi_awvalid_i && m_axis_req_tready_i) state_next = AW_SEND;
            end
            AW_SEND: begin
                m_axis_req_tvalid_o = s_axi_awvalid_i;    // AW is still held from the header cycle.
                m_axis_req_o.tdata = aw_flit;
                m_axis_req_o.tid = AW_SUBHEADER;
                s_axi_awready_o = m_axis_req_tready_i;
                if (s_axi_awvalid_i && m_axis_req_tready_i) state_next = W_SEND;
            end
            W_SEND: begin
                m_axis_req_tvalid_o = s_axi_wvalid_i;
                m_axis_req_o.tdata = w_flit;
                m_axis_req_o.tstrb = s_axi_w_i.wstrb;
                m_axis_req_o.tid = W_DATA;
                m_axis_req_o.tlast = s_axi_w_i.wlast;
                s_axi_wready_o = m_axis_req_tready_i;
                if (s_axi_wvalid_i && m_axis_req_tready_i && s_axi_w_i.wlast) begin
                    state_next = HEADER;
                end
            end
            default: state_next = HEADER;
        endcase
    end

    // Holds only if the local master keeps its AW and W beats stable as AXI requires.
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_axis_req_tvalid_o && !m_axis_req_tready_i |=>
            m_axis_req_tvalid_o && $stable(m_axis_req_o));

    // The AW beat stays valid from its header until its own flit is sent.
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        state == AW_SEND |-> s_axi_awvalid_i);

endmodule

// ==== design/write_depacketizer.sv ====
`timescale 1ns/1ns

module write_depacketizer (
    input  logic ACLK,
    input  logic ARESETn,

    input  noc_bridge_pkg::flit_t s_axis_req_i,
    input  logic s_axis_req_tvalid_i,
    output logic s_axis_req_tready_o,

    output noc_bridge_pkg::axi_aw_t m_axi_aw_o,
    output logic m_axi_awvalid_o,
    input  logic m_axi_awready_i,
    output noc_bridge_pkg::axi_w_t m_axi_w_o,
    output logic m_axi_wvalid_o,
    input  logic m_axi_wready_i,

    output noc_bridge_pkg::coord_x_t bresp_dest_x_o,
    output noc_bridge_pkg::coord_y_t bresp_dest_y_o
);

    import noc_bridge_pkg::*;

    routing_header_t header;
    aw_subheader_t aw_flit;
    w_flit_t w_flit;
    coord_x_t src_x_q;
    coord_y_t src_y_q;
    coord_x_t dest_x_q;
    coord_y_t dest_y_q;
    logic header_take;
    logic aw_take;

    always_comb begin
        header = s_axis_req_i.tdata;
        aw_flit = s_axis_req_i.tdata;
        w_flit = s_axis_req_i.tdata;

        m_axi_aw_o.awid = aw_flit.id;
        m_axi_aw_o.awaddr = aw_flit.addr;
        m_axi_aw_o.awlen = aw_flit.len;
        m_axi_aw_o.awsize = aw_flit.size;
        m_axi_aw_o.awburst = aw_flit.burst;

        m_axi_w_o.wdata = w_flit.data;
        m_axi_w_o.wstrb = s_axis_req_i.tstrb;
        m_axi_w_o.wlast = s_axis_req_i.tlast;
    end

    // Headers and unknown kinds are consumed at once.
    always_comb begin
        s_axis_req_tready_o = 1'b1;
        m_axi_awvalid_o = 1'b0;
        m_axi_wvalid_o = 1'b0;
        if (s_axis_req_tvalid_i) begin
            case (s_axis_req_i.tid)
                AW_SUBHEADER: begin
                    m_axi_awvalid_o = 1'b1;
                    s_axis_req_tready_o = m_axi_awready_i;
                end
                W_DATA: begin
                    m_axi_wvalid_o = 1'b1;
                    s_axis_req_tready_o = m_axi_wready_i;
                end
                default: s_axis_req_tready_o = 1'b1;
            endcase
        end
    end

    assign header_take = s_axis_req_tvalid_i && s_axis_req_i.tid == ROUTING_HEADER;
    assign aw_take = m_axi_awvalid_o && m_axi_awready_i;

    // One write in flight, so a single return address is enough.
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            src_x_q <= '0;
            src_y_q <= '0;
            dest_x_q <= '0;
            dest_y_q <= '0;
        end else begin
            if (header_take) begin
                src_x_q <= header.src_x;
                src_y_q <= header.src_y;
            end
            if (aw_take) begin
                dest_x_q <= src_x_q;
                dest_y_q <= src_y_q;
            end
        end
    end

    assign bresp_dest_x_o = dest_x_q;
    assign bresp_dest_y_o = dest_y_q;

    // WVALID may not drop before WREADY, so the network must hold the W flit.
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        m_axi_wvalid_o && !m_axi_wready_i |=> m_axi_wvalid_o && $stable(m_axi_w_o));

endmodule

// ==== design/bresp_packetizer.sv ====
`timescale 1ns/1ns

module bresp_packetizer #(
    parameter noc_bridge_pkg::coord_x_t ROUTER_X = '0,
    parameter noc_bridge_pkg::coord_y_t ROUTER_Y = '0
) (
    input  logic ACLK,
    input  logic ARESETn,

    input  noc_bridge_pkg::axi_b_t m_axi_b_i,
    input  logic m_axi_bvalid_i,
    output logic m_axi_bready_o,

    input  noc_bridge_pkg::coord_x_t bresp_dest_x_i,
    input  noc_bridge_pkg::coord_y_t bresp_dest_y_i,

    output noc_bridge_pkg::flit_t m_axis_resp_o,
    output logic m_axis_resp_tvalid_o,
    input  logic m_axis_resp_tready_i
);

    import noc_bridge_pkg::*;

    typedef enum logic {HEADER, B_SEND} state_t;

    state_t state, state_next;
    routing_header_t header;
    b_subheader_t b_flit;

    always_comb begin
        header.rsvd = '0;
        header.packet_count = pkt_count_t'(1);    // The B flit alone follows the header.
        header.src_x = ROUTER_X;
        header.src_y = ROUTER_Y;
        header.dst_x = bresp_dest_x_i;
        header.dst_y = bresp_dest_y_i;

        b_flit.rsvd = '0;
        b_flit.id = m_axi_b_i.bid;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state <= HEADER;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        m_axi_bready_o = 1'b0;
        m_axis_resp_tvalid_o = m_axi_bvalid_i;
        m_axis_resp_o.tstrb = '1;
        if (state == B_SEND) begin
            m_axis_resp_o.tdata = b_flit;
            m_axis_resp_o.tid = B_SUBHEADER;
            m_axis_resp_o.tlast = 1'b1;
            m_axi_bready_o = m_axis_resp_tready_i;
            if (m_axi_bvalid_i && m_axis_resp_tready_i) state_next = HEADER;
        end else begin
            m_axis_resp_o.tdata = header;
            m_axis_resp_o.tid = ROUTING_HEADER;
            m_axis_resp_o.tlast = 1'b0;
            if (m_axi_bvalid_i && m_axis_resp_tready_i) state_next = B_SEND;
        end
    end

    // The local slave holds its B beat from the header until BREADY, which comes with the B flit.
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        state == B_SEND |-> m_axi_bvalid_i && $stable(m_axi_b_i));

endmodule

// ==== design/bresp_depacketizer.sv ====
`timescale 1ns/1ns

module bresp_depacketizer (
    input  logic ACLK,
    input  logic ARESETn,

    input  noc_bridge_pkg::flit_t s_axis_resp_i,
    input  logic s_axis_resp_tvalid_i,
    output logic s_axis_resp_tready_o,

    output noc_bridge_pkg::axi_b_t s_axi_b_o,
    output logic s_axi_bvalid_o,
    input  logic s_axi_bready_i
);

    import noc_bridge_pkg::*;

    b_subheader_t b_flit;
    logic is_b;

    assign b_flit = s_axis_resp_i.tdata;
    assign is_b = s_axis_resp_i.tid == B_SUBHEADER;

    // Headers are swallowed; only the B flit reaches the local master.
    always_comb begin
        s_axi_b_o.bid = b_flit.id;
        s_axi_bvalid_o = s_axis_resp_tvalid_i && is_b;
        s_axis_resp_tready_o = 1'b1;
        if (s_axis_resp_tvalid_i && is_b) s_axis_resp_tready_o = s_axi_bready_i;
    end

    // Relies on the network holding a flit until it is taken.
    assert property (@(posedge ACLK) disable iff (!ARESETn)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_b_o));

endmodule

// ==== design/noc_write_bridge.sv ====
`timescale 1ns/1ns

module noc_write_bridge #(
    parameter noc_bridge_pkg::coord_x_t ROUTER_X = '0,
    parameter noc_bridge_pkg::coord_y_t ROUTER_Y = '0
) (
    input  logic ACLK,
    input  logic ARESETn,

    input  noc_bridge_pkg::axi_aw_t s_axi_aw_i,
    input  logic s_axi_awvalid_i,
    output logic s_axi_awready_o,
    input  noc_bridge_pkg::axi_w_t s_axi_w_i,
    input  logic s_axi_wvalid_i,
    output logic s_axi_wready_o,
    output noc_bridge_pkg::axi_b_t s_axi_b_o,
    output logic s_axi_bvalid_o,
    input  logic s_axi_bready_i,

    output noc_bridge_pkg::axi_aw_t m_axi_aw_o,
    output logic m_axi_awvalid_o,
    input  logic m_axi_awready_i,
    output noc_bridge_pkg::axi_w_t m_axi_w_o,
    output logic m_axi_wvalid_o,
    input  logic m_axi_wready_i,
    input  noc_bridge_pkg::axi_b_t m_axi_b_i,
    input  logic m_axi_bvalid_i,
    output logic m_axi_bready_o,

    output noc_bridge_pkg::flit_t m_axis_req_o,
    output logic m_axis_req_tvalid_o,
    input  logic m_axis_req_tready_i,
    input  noc_bridge_pkg::flit_t s_axis_req_i,
    input  logic s_axis_req_tvalid_i,
    output logic s_axis_req_tready_o,

    output noc_bridge_pkg::flit_t m_axis_resp_o,
    output logic m_axis_resp_tvalid_o,
    input  logic m_axis_resp_tready_i,
    input  noc_bridge_pkg::flit_t s_axis_resp_i,
    input  logic s_axis_resp_tvalid_i,
    output logic s_axis_resp_tready_o
);

    import noc_bridge_pkg::*;

    coord_x_t bresp_dest_x;    // Requester of the write now served locally.
    coord_y_t bresp_dest_y;

    write_packetizer #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) u_write_packetizer (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .s_axi_aw_i(s_axi_aw_i), .s_axi_awvalid_i(s_axi_awvalid_i),
        .s_axi_awready_o(s_axi_awready_o),
        .s_axi_w_i(s_axi_w_i), .s_axi_wvalid_i(s_axi_wvalid_i), .s_axi_wready_o(s_axi_wready_o),
        .m_axis_req_o(m_axis_req_o), .m_axis_req_tvalid_o(m_axis_req_tvalid_o),
        .m_axis_req_tready_i(m_axis_req_tready_i)
    );

    write_depacketizer u_write_depacketizer (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .s_axis_req_i(s_axis_req_i), .s_axis_req_tvalid_i(s_axis_req_tvalid_i),
        .s_axis_req_tready_o(s_axis_req_tready_o),
        .m_axi_aw_o(m_axi_aw_o), .m_axi_awvalid_o(m_axi_awvalid_o),
        .m_axi_awready_i(m_axi_awready_i),
        .m_axi_w_o(m_axi_w_o), .m_axi_wvalid_o(m_axi_wvalid_o), .m_axi_wready_i(m_axi_wready_i),
        .bresp_dest_x_o(bresp_dest_x), .bresp_dest_y_o(bresp_dest_y)
    );

    bresp_packetizer #(.ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)) u_bresp_packetizer (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .m_axi_b_i(m_axi_b_i), .m_axi_bvalid_i(m_axi_bvalid_i), .m_axi_bready_o(m_axi_bready_o),
        .bresp_dest_x_i(bresp_dest_x), .bresp_dest_y_i(bresp_dest_y),
        .m_axis_resp_o(m_axis_resp_o), .m_axis_resp_tvalid_o(m_axis_resp_tvalid_o),
        .m_axis_resp_tready_i(m_axis_resp_tready_i)
    );

    bresp_depacketizer u_bresp_depacketizer (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .s_axis_resp_i(s_axis_resp_i), .s_axis_resp_tvalid_i(s_axis_resp_tvalid_i),
        .s_axis_resp_tready_o(s_axis_resp_tready_o),
        .s_axi_b_o(s_axi_b_o), .s_axi_bvalid_o(s_axi_bvalid_o), .s_axi_bready_i(s_axi_bready_i)
    );

endmodule

// ==== sim/tb_noc_write_bridge.sv ====
`timescale 1ns/1ns

module tb_noc_write_bridge;

    import noc_bridge_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_ROWS = 4;
    localparam int MAX_CYCLES = 100;    // Cycle limit of one test is far above the longest packet.

    typedef struct packed {
        axi_id_t awid;
        axi_addr_t addr;
        burst_len_t awlen;
        axi_data_t data0;
        coord_x_t src_x;
        coord_y_t src_y;
        axi_id_t bid;
    } row_t;

    logic ACLK = 1'b0;
    logic ARESETn;
    axi_aw_t s_axi_aw, m_axi_aw;
    axi_w_t s_axi_w, m_axi_w;
    axi_b_t s_axi_b, m_axi_b;
    flit_t m_axis_req, s_axis_req, m_axis_resp, s_axis_resp;
    logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready, s_axi_bvalid, s_axi_bready;
    logic m_axi_awvalid, m_axi_awready, m_axi_wvalid, m_axi_wready, m_axi_bvalid, m_axi_bready;
    logic m_axis_req_tvalid, m_axis_req_tready, s_axis_req_tvalid, s_axis_req_tready;
    logic m_axis_resp_tvalid, m_axis_resp_tready, s_axis_resp_tvalid, s_axis_resp_tready;

    row_t rows [N_ROWS];
    flit_t pkt_q[$];    // Flits of the packet under test, expected or driven.
    logic [31:0] rng_state = 32'h1b58;
    int check_count = 0;
    int error_count = 0;
    int test_count = 0;

    always #(CLK_PERIOD / 2) ACLK = ~ACLK;

    noc_write_bridge #(.ROUTER_X(2'd1), .ROUTER_Y(2'd2)) dut (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .s_axi_aw_i(s_axi_aw), .s_axi_awvalid_i(s_axi_awvalid), .s_axi_awready_o(s_axi_awready),
        .s_axi_w_i(s_axi_w), .s_axi_wvalid_i(s_axi_wvalid), .s_axi_wready_o(s_axi_wready),
        .s_axi_b_o(s_axi_b), .s_axi_bvalid_o(s_axi_bvalid), .s_axi_bready_i(s_axi_bready),
        .m_axi_aw_o(m_axi_aw), .m_axi_awvalid_o(m_axi_awvalid), .m_axi_awready_i(m_axi_awready),
        .m_axi_w_o(m_axi_w), .m_axi_wvalid_o(m_axi_wvalid), .m_axi_wready_i(m_axi_wready),
        .m_axi_b_i(m_axi_b), .m_axi_bvalid_i(m_axi_bvalid), .m_axi_bready_o(m_axi_bready),
        .m_axis_req_o(m_axis_req), .m_axis_req_tvalid_o(m_axis_req_tvalid),
        .m_axis_req_tready_i(m_axis_req_tready),
        .s_axis_req_i(s_axis_req), .s_axis_req_tvalid_i(s_axis_req_tvalid),
        .s_axis_req_tready_o(s_axis_req_tready),
        .m_axis_resp_o(m_axis_resp), .m_axis_resp_tvalid_o(m_axis_resp_tvalid),
        .m_axis_resp_tready_i(m_axis_resp_tready),
        .s_axis_resp_i(s_axis_resp), .s_axis_resp_tvalid_i(s_axis_resp_tvalid),
        .s_axis_resp_tready_o(s_axis_resp_tready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // High about three cycles in four.
    function automatic logic random_ready();
        rng_state = xorshift32(rng_state);
        return rng_state[0] | rng_state[1];
    endfunction

    function automatic flit_t make_flit(input logic [FLIT_W-1:0] data, input axi_strb_t strb,
                                        input flit_kind_t kind, input logic last);
        flit_t f;
        f.tdata = data;
        f.tstrb = strb;
        f.tid = kind;
        f.tlast = last;
        return f;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flit(input flit_t got, input flit_t exp, input string what);
        check_value(got.tdata, exp.tdata, {what, " TDATA"});
        check_value(got.tid, exp.tid, {what, " TID"});
        check_value(got.tlast, exp.tlast, {what, " TLAST"});
        if (exp.tid == W_DATA) check_value(got.tstrb, exp.tstrb, {what, " TSTRB"});
    endtask

    task automatic report_test(input int n, input string name, input int errors_before,
                               input int cycles);
        test_count++;
        if (cycles >= MAX_CYCLES) begin
            error_count++;
            $display("Row %0d %s: handshakes did not finish in %0d cycles", n, name, MAX_CYCLES);
        end
        if (error_count == errors_before) $display("Row %0d %s: ok", n, name);
        else $display("Row %0d %s: %0d errors", n, name, error_count - errors_before);
    endtask

    // Header plus AW and W flits, or header plus B flit for a response.
    task automatic build_packet(input row_t r, input bit response, input int sx, input int sy,
                                input int dx, input int dy);
        routing_header_t h;
        aw_subheader_t a;
        w_flit_t w;
        b_subheader_t b;
        axi_data_t word;
        pkt_q.delete();
        h = '0;
        h.packet_count = response ? 8'd1 : pkt_count_t'(r.awlen + 8'd2);
        h.src_x = coord_x_t'(sx);
        h.src_y = coord_y_t'(sy);
        h.dst_x = coord_x_t'(dx);
        h.dst_y = coord_y_t'(dy);
        pkt_q.push_back(make_flit(h, 4'hf, ROUTING_HEADER, 1'b0));
        if (response) begin
            b = '0;
            b.id = r.bid;
            pkt_q.push_back(make_flit(b, 4'hf, B_SUBHEADER, 1'b1));
        end else begin
            a = '0;
            a.id = r.awid;
            a.addr = r.addr;
            a.len = r.awlen;
            a.size = 3'd2;
            a.burst = 2'b01;
            pkt_q.push_back(make_flit(a, 4'hf, AW_SUBHEADER, 1'b0));
            word = r.data0;
            for (int i = 0; i <= int'(r.awlen); i++) begin
                w = '0;
                w.data = word;
                pkt_q.push_back(make_flit(w, word[7:4], W_DATA, i == int'(r.awlen)));
                word = xorshift32(word);
            end
        end
    endtask

    task automatic run_outgoing(input int n, input bit stall);
        row_t r;
        w_flit_t wf;
        int flit_idx;
        int w_idx;
        int aw_count;
        int w_count;
        int cycles;
        int errors_before;
        bit last_seen;
        r = rows[n];
        errors_before = error_count;
        build_packet(r, 1'b0, 1, 2, (int'(r.awid) - 1) % MESH_X, (int'(r.awid) - 1) / MESH_X);
        flit_idx = 0;
        aw_count = 0;
        w_count = 0;
        cycles = 0;
        last_seen = 1'b0;
        while (!last_seen && cycles < MAX_CYCLES) begin
            // After its last beat the master offers that beat again, which the DUT must not take.
            w_idx = (w_count <= int'(r.awlen)) ? 2 + w_count : pkt_q.size() - 1;
            wf = pkt_q[w_idx].tdata;
            @(negedge ACLK);
            s_axi_aw = {r.awid, r.addr, r.awlen, 3'd2, 2'b01};
            s_axi_awvalid = (aw_count == 0);
            s_axi_w = {wf.data, pkt_q[w_idx].tstrb, pkt_q[w_idx].tlast};
            s_axi_wvalid = 1'b1;
            m_axis_req_tready = stall ? random_ready() : 1'b1;
            @(posedge ACLK);
            if (m_axis_req_tvalid && m_axis_req_tready) begin
                if (flit_idx < pkt_q.size()) begin
                    compare_flit(m_axis_req, pkt_q[flit_idx],
                                 $sformatf("request flit %0d", flit_idx));
                end
                last_seen = m_axis_req.tlast;
                flit_idx++;
            end
            aw_count += int'(s_axi_awvalid && s_axi_awready);
            w_count += int'(s_axi_wvalid && s_axi_wready);
            cycles++;
        end
        @(negedge ACLK);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        m_axis_req_tready = 1'b0;
        check_value(flit_idx, pkt_q.size(), "request flit count");
        check_value(aw_count, 1, "AWREADY transfers");
        check_value(w_count, int'(r.awlen) + 1, "WREADY transfers");
        report_test(n, stall ? "outgoing write, random ready" : "outgoing write", errors_before,
                    cycles);
    endtask

    task automatic run_incoming(input int n);
        row_t r;
        w_flit_t wf;
        int idx;
        int aw_count;
        int w_count;
        int cycles;
        int errors_before;
        r = rows[n];
        errors_before = error_count;
        build_packet(r, 1'b0, r.src_x, r.src_y, 1, 2);
        idx = 0;
        aw_count = 0;
        w_count = 0;
        cycles = 0;
        while (idx < pkt_q.size() && cycles < MAX_CYCLES) begin
            @(negedge ACLK);
            s_axis_req = pkt_q[idx];
            s_axis_req_tvalid = 1'b1;
            m_axi_awready = random_ready();
            m_axi_wready = random_ready();
            @(posedge ACLK);
            if (m_axi_awvalid && m_axi_awready) begin
                check_value(m_axi_aw, {r.awid, r.addr, r.awlen, 3'd2, 2'b01}, "AW beat");
                aw_count++;
            end
            if (m_axi_wvalid && m_axi_wready) begin
                wf = pkt_q[2 + w_count].tdata;
                check_value(aw_count, 1, "AW beats before W beat");
                check_value(m_axi_w, {wf.data, pkt_q[2 + w_count].tstrb, w_count == int'(r.awlen)},
                            $sformatf("W beat %0d", w_count));
                w_count++;
            end
            idx += int'(s_axis_req_tready);
            cycles++;
        end
        @(negedge ACLK);
        s_axis_req_tvalid = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready = 1'b0;
        check_value(aw_count, 1, "AW beat count");
        check_value(w_count, int'(r.awlen) + 1, "W beat count");
        report_test(n, "incoming request", errors_before, cycles);
    endtask

    // The return address comes from the incoming request of the same row.
    task automatic run_bresp_out(input int n);
        row_t r;
        int flit_idx;
        int b_count;
        int cycles;
        int errors_before;
        r = rows[n];
        errors_before = error_count;
        build_packet(r, 1'b1, 1, 2, r.src_x, r.src_y);
        flit_idx = 0;
        b_count = 0;
        cycles = 0;
        while (b_count == 0 && cycles < MAX_CYCLES) begin
            @(negedge ACLK);
            m_axi_b.bid = r.bid;
            m_axi_bvalid = 1'b1;
            m_axis_resp_tready = random_ready();
            @(posedge ACLK);
            if (m_axis_resp_tvalid && m_axis_resp_tready) begin
                if (flit_idx < pkt_q.size()) begin
                    compare_flit(m_axis_resp, pkt_q[flit_idx],
                                 $sformatf("response flit %0d", flit_idx));
                end
                flit_idx++;
            end
            b_count += int'(m_axi_bready);
            cycles++;
        end
        @(negedge ACLK);
        m_axi_bvalid = 1'b0;
        m_axis_resp_tready = 1'b0;
        check_value(flit_idx, 2, "response flit count");
        report_test(n, "outgoing response", errors_before, cycles);
    endtask

    task automatic run_bresp_in(input int n);
        row_t r;
        int idx;
        int b_count;
        int cycles;
        int errors_before;
        r = rows[n];
        errors_before = error_count;
        build_packet(r, 1'b1, r.src_x, r.src_y, 1, 2);
        idx = 0;
        b_count = 0;
        cycles = 0;
        while (idx < 2 && cycles < MAX_CYCLES) begin
            @(negedge ACLK);
            s_axis_resp = pkt_q[idx];
            s_axis_resp_tvalid = 1'b1;
            s_axi_bready = (cycles >= 3);    // The B beat waits two cycles first.
            @(posedge ACLK);
            check_value(s_axi_bvalid, idx == 1, $sformatf("BVALID on flit %0d", idx));
            if (s_axi_bvalid) check_value(s_axi_b.bid, r.bid, "BID");
            b_count += int'(s_axi_bvalid && s_axi_bready);
            idx += int'(s_axis_resp_tready);
            cycles++;
        end
        @(negedge ACLK);
        s_axis_resp_tvalid = 1'b0;
        s_axi_bready = 1'b0;
        check_value(b_count, 1, "B beat count");
        report_test(n, "incoming response", errors_before, cycles);
    endtask

    initial begin
        ARESETn = 1'b0;
        {s_axi_awvalid, s_axi_wvalid, s_axi_bready, m_axi_awready, m_axi_wready} = '0;
        {m_axi_bvalid, m_axis_req_tready, s_axis_req_tvalid} = '0;
        {m_axis_resp_tready, s_axis_resp_tvalid} = '0;
        s_axi_aw = '0;
        s_axi_w = '0;
        m_axi_b = '0;
        s_axis_req = '0;
        s_axis_resp = '0;
        rows[0] = {4'd1, 16'h0100, 8'd0, 32'h0000_1b58, 2'd3, 2'd0, 4'd5};
        rows[1] = {4'd6, 16'h2a40, 8'd3, 32'hc0de_0042, 2'd0, 2'd1, 4'd9};
        rows[2] = {4'd12, 16'h7ffc, 8'd1, 32'h8000_0001, 2'd2, 2'd3, 4'd2};
        rows[3] = {4'd15, 16'hf008, 8'd7, 32'h1234_5678, 2'd1, 2'd0, 4'd14};
        repeat (5) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        for (int n = 0; n < N_ROWS; n++) begin
            run_outgoing(n, 1'b0);
            run_outgoing(n, 1'b1);
            run_incoming(n);
            run_bresp_out(n);
            run_bresp_in(n);
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(N_ROWS * 200 * CLK_PERIOD);
        $display("Run timed out after %0d cycles", N_ROWS * 200);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== list.f ====
design/noc_bridge_pkg.sv
design/write_packetizer.sv
design/write_depacketizer.sv
design/bresp_packetizer.sv
design/bresp_depacketizer.sv
design/noc_write_bridge.sv
sim/tb_noc_write_bridge.sv
